// File: Makefile
# Verilator build and run for the core bus bridge testbench
VERILATOR ?= verilator
TOP       ?= tb_core_bus_bridge
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is shown and searched for the pass message, no log file kept
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/axi_bus_fsm.sv
// AXI4-Lite handshake sequencer
// Mealy FSM that drives the AW/W/B or AR/R handshakes for one access at a
// time and pulses done with the response error in the completing cycle
`timescale 1ns/1ps
`default_nettype none

module axi_bus_fsm import core_bus_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst_n,
    input  wire logic     i_sel_valid,   // Arbiter holds a grant
    input  wire logic     i_wen,         // Granted access is a write
    input  wire axi_s2m_t i_axi,
    output logic          o_awvalid,
    output logic          o_wvalid,
    output logic          o_arvalid,
    output logic          o_rready,
    output logic          o_done,
    output logic          o_err
);

    typedef enum logic [2:0] {
        IDLE,
        SEND_RADDR,    // AR not yet taken
        GET_RDATA,     // AR taken, waiting on R
        SEND_WADDR,    // W taken, AW still pending
        SEND_WDATA,    // AW taken, W still pending
        GET_BRESP      // Both taken, waiting on B
    } state_e;

    state_e state;
    state_e next_state;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Each ready below is only looked at in a branch that raises the
    // matching valid, so ready alone means the transfer happens
    always_comb begin
        next_state = state;
        o_awvalid  = 1'b0;
        o_wvalid   = 1'b0;
        o_arvalid  = 1'b0;
        o_rready   = 1'b0;
        o_done     = 1'b0;

        case (state)
            IDLE: begin
                if (i_sel_valid) begin
                    if (i_wen) begin
                        o_awvalid = 1'b1;            // Address and data together
                        o_wvalid  = 1'b1;
                        if (i_axi.awready && i_axi.wready) begin
                            next_state = GET_BRESP;
                        end else if (i_axi.awready) begin
                            next_state = SEND_WDATA;
                        end else if (i_axi.wready) begin
                            next_state = SEND_WADDR; // Data went first
                        end
                    end else begin
                        o_arvalid = 1'b1;
                        o_rready  = 1'b1;
                        if (i_axi.arready && i_axi.rvalid) begin
                            o_done = 1'b1;           // Whole read in one cycle
                        end else if (i_axi.arready) begin
                            next_state = GET_RDATA;
                        end else begin
                            next_state = SEND_RADDR;
                        end
                    end
                end
            end
            SEND_RADDR: begin
                o_arvalid = 1'b1;                    // Keep offering the address
                o_rready  = 1'b1;
                if (i_axi.arready && i_axi.rvalid) begin
                    o_done     = 1'b1;
                    next_state = IDLE;
                end else if (i_axi.arready) begin
                    next_state = GET_RDATA;
                end
            end
            GET_RDATA: begin
                o_rready = 1'b1;
                if (i_axi.rvalid) begin
                    o_done     = 1'b1;               // Read ends on R transfer
                    next_state = IDLE;
                end
            end
            SEND_WADDR: begin
                o_awvalid = 1'b1;                    // W already transferred
                if (i_axi.awready) begin
                    next_state = GET_BRESP;
                end
            end
            SEND_WDATA: begin
                o_wvalid = 1'b1;                     // AW already transferred
                if (i_axi.wready) begin
                    next_state = GET_BRESP;
                end
            end
            GET_BRESP: begin
                // bready is tied high at the top
                if (i_axi.bvalid) begin
                    o_done     = 1'b1;
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Completing response is B for writes and R for reads
    assign o_err = i_wen ? (i_axi.bresp != RESP_OKAY) : (i_axi.rresp != RESP_OKAY);

endmodule : axi_bus_fsm

`default_nettype wire

// File: design/core_bus_bridge.sv
// Core memory bus bridge
// Shares one AXI4-Lite manager port between the MMU walker, I-cache and
// D-cache with round-robin arbitration and sub-word lane steering
`timescale 1ns/1ps
`default_nettype none

module core_bus_bridge import core_bus_pkg::*; (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst_n,
    input  wire logic [NUM_REQ-1:0]             i_valid,
    input  wire bus_req_t [NUM_REQ-1:0]         i_req,
    output logic [NUM_REQ-1:0]                  o_ready,
    output logic [NUM_REQ-1:0][DATA_W-1:0]      o_rdata,
    output logic [NUM_REQ-1:0]                  o_err,
    output axi_m2s_t                            o_axi,
    input  wire axi_s2m_t                       i_axi
);

    logic                 sel_valid;
    logic [REQ_IDX_W-1:0] sel_idx;
    bus_req_t             sel_req;
    logic                 acc_done;      // One-cycle completion pulse
    logic                 acc_err;
    logic [ADDR_W-1:0]    aligned_addr;
    logic [DATA_W-1:0]    steered_rdata;

    req_arbiter u_arbiter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_req       (i_req),
        .i_done      (acc_done),
        .o_sel_valid (sel_valid),
        .o_sel_idx   (sel_idx),
        .o_sel_req   (sel_req),
        .o_ready     (o_ready)
    );

    axi_bus_fsm u_fsm (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_sel_valid (sel_valid),
        .i_wen       (sel_req.wen),
        .i_axi       (i_axi),
        .o_awvalid   (o_axi.awvalid),
        .o_wvalid    (o_axi.wvalid),
        .o_arvalid   (o_axi.arvalid),
        .o_rready    (o_axi.rready),
        .o_done      (acc_done),
        .o_err       (acc_err)
    );

    lane_steer u_steer (
        .i_req   (sel_req),
        .i_rdata (i_axi.rdata),
        .o_addr  (aligned_addr),
        .o_wdata (o_axi.wdata),
        .o_wstrb (o_axi.wstrb),
        .o_rdata (steered_rdata)
    );

    assign o_axi.awaddr = aligned_addr;   // Reads and writes share the address
    assign o_axi.araddr = aligned_addr;
    assign o_axi.bready = 1'b1;           // B never precedes AW and W

    // Read data to everyone, error flag only to the granted requester
    always_comb begin
        for (int k = 0; k < NUM_REQ; k++) begin
            o_rdata[k] = steered_rdata;
            o_err[k]   = acc_err && sel_valid && (sel_idx == REQ_IDX_W'(k));
        end
    end

endmodule : core_bus_bridge

`default_nettype wire

// File: design/core_bus_pkg.sv
// Core memory bus package
// Shared widths, access size encoding, requester request word and the
// AXI4-Lite manager/target channel bundles used by the bus bridge
`default_nettype none

package core_bus_pkg;

    // Requesters: 0 = MMU page walker, 1 = instruction cache, 2 = data cache
    localparam int NUM_REQ   = 3;
    localparam int REQ_IDX_W = 2;   // Enough to index NUM_REQ requesters

    localparam int ADDR_W = 32;     // Physical address
    localparam int DATA_W = 32;     // One bus word
    localparam int STRB_W = DATA_W / 8;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Access width of a single request
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    // One requester access, held stable until o_ready
    typedef struct packed {
        logic              wen;     // 1 = write, 0 = read
        size_e             size;
        logic [ADDR_W-1:0] addr;    // Byte address, low bits pick lanes
        logic [DATA_W-1:0] wdata;   // Right-justified write data
    } bus_req_t;

    // Everything the manager drives
    typedef struct packed {
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              bready;
        logic              arvalid;
        logic [ADDR_W-1:0] araddr;
        logic              rready;
    } axi_m2s_t;

    // Everything the target drives
    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [1:0]        bresp;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        logic [1:0]        rresp;
    } axi_s2m_t;

endpackage : core_bus_pkg

`default_nettype wire

// File: design/lane_steer.sv
// Sub-word lane steering
// Word-aligns the address, builds write strobes, replicates write data
// across lanes and extracts the addressed read lane with zero extension
`timescale 1ns/1ps
`default_nettype none

module lane_steer import core_bus_pkg::*; (
    input  wire bus_req_t            i_req,
    input  wire logic [DATA_W-1:0]   i_rdata,   // Raw AXI read word
    output logic [ADDR_W-1:0]        o_addr,
    output logic [DATA_W-1:0]        o_wdata,
    output logic [STRB_W-1:0]        o_wstrb,
    output logic [DATA_W-1:0]        o_rdata
);

    logic [1:0] offs;                // Byte offset within the word

    assign offs   = i_req.addr[1:0];
    assign o_addr = {i_req.addr[ADDR_W-1:2], 2'b00};   // Lanes handle the rest

    // Write strobe
    always_comb begin
        case (i_req.size)
            SIZE_BYTE: o_wstrb = STRB_W'(1) << offs;       // One-hot lane
            SIZE_HALF: o_wstrb = offs[1] ? 4'b1100 : 4'b0011;
            default:   o_wstrb = 4'b1111;                 // Word
        endcase
    end

    // Replicate so the data lands in the strobed lane at any offset
    always_comb begin
        case (i_req.size)
            SIZE_BYTE: o_wdata = {4{i_req.wdata[7:0]}};
            SIZE_HALF: o_wdata = {2{i_req.wdata[15:0]}};
            default:   o_wdata = i_req.wdata;
        endcase
    end

    // Read lane select, zero-extended
    always_comb begin
        case (i_req.size)
            SIZE_BYTE: begin
                case (offs)
                    2'd0:    o_rdata = {24'h0, i_rdata[7:0]};
                    2'd1:    o_rdata = {24'h0, i_rdata[15:8]};
                    2'd2:    o_rdata = {24'h0, i_rdata[23:16]};
                    default: o_rdata = {24'h0, i_rdata[31:24]};
                endcase
            end
            SIZE_HALF: begin
                if (offs[1]) begin
                    o_rdata = {16'h0, i_rdata[31:16]};  // Upper half
                end else begin
                    o_rdata = {16'h0, i_rdata[15:0]};
                end
            end
            default: o_rdata = i_rdata;
        endcase
    end

endmodule : lane_steer

`default_nettype wire

// File: design/req_arbiter.sv
// Round-robin requester arbiter
// Registers a grant and holds it until the bus access completes, muxes the
// granted request out and routes the completion pulse back to its owner
`timescale 1ns/1ps
`default_nettype none

module req_arbiter import core_bus_pkg::*; (
    input  wire logic                     i_clk,
    input  wire logic                     i_rst_n,
    input  wire logic [NUM_REQ-1:0]       i_valid,
    input  wire bus_req_t [NUM_REQ-1:0]   i_req,
    input  wire logic                     i_done,      // Access finished this cycle
    output logic                          o_sel_valid,
    output logic [REQ_IDX_W-1:0]          o_sel_idx,
    output bus_req_t                      o_sel_req,
    output logic [NUM_REQ-1:0]            o_ready
);

    logic                 grant_vld;
    logic [REQ_IDX_W-1:0] grant_idx;
    logic [REQ_IDX_W-1:0] last_idx;    // Last requester served
    logic                 found;
    logic [REQ_IDX_W-1:0] next_idx;

    // Search upward from the one after last_idx, wrapping past NUM_REQ-1
    always_comb begin
        logic [REQ_IDX_W:0] cand;      // One extra bit for the wrap
        found    = 1'b0;
        next_idx = '0;
        for (int i = 0; i < NUM_REQ; i++) begin
            cand = {1'b0, last_idx} + (REQ_IDX_W+1)'(i + 1);
            if (cand >= (REQ_IDX_W+1)'(NUM_REQ)) begin
                cand = cand - (REQ_IDX_W+1)'(NUM_REQ);
            end
            if (!found && i_valid[cand[REQ_IDX_W-1:0]]) begin
                found    = 1'b1;
                next_idx = cand[REQ_IDX_W-1:0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            grant_vld <= 1'b0;
            grant_idx <= '0;
            last_idx  <= REQ_IDX_W'(NUM_REQ - 1);  // First search starts at 0
        end else if (grant_vld) begin
            if (i_done) begin
                grant_vld <= 1'b0;       // Release, no regrant on this edge
                last_idx  <= grant_idx;
            end
        end else if (found) begin
            grant_vld <= 1'b1;
            grant_idx <= next_idx;
        end
    end

    assign o_sel_valid = grant_vld;
    assign o_sel_idx   = grant_idx;
    assign o_sel_req   = i_req[grant_idx];

    // Completion pulse goes to the granted requester only
    always_comb begin
        for (int k = 0; k < NUM_REQ; k++) begin
            o_ready[k] = grant_vld && i_done && (grant_idx == REQ_IDX_W'(k));
        end
    end

endmodule : req_arbiter

`default_nettype wire

// File: project.f
design/core_bus_pkg.sv
design/req_arbiter.sv
design/lane_steer.sv
design/axi_bus_fsm.sv
design/core_bus_bridge.sv
sim/axi_mem_model.sv
sim/tb_core_bus_bridge.sv

// File: sim/axi_mem_model.sv
// AXI4-Lite memory target model
// 256 words with xorshift-random ready and response delays, and an
// error region at 0x800 and up that answers SLVERR and stores nothing
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import core_bus_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_rst_n,
    input  wire axi_m2s_t i_axi,
    output axi_s2m_t      o_axi
);

    localparam logic [ADDR_W-1:0] ERR_BASE = 32'h0000_0800;

    logic [DATA_W-1:0] mem [256];
    logic [31:0]       rng;
    logic [1:0]        aw_dly;
    logic [1:0]        w_dly;
    logic [1:0]        ar_dly;
    logic [1:0]        rsp_dly;        // B and R are never pending together
    logic              aw_got;
    logic              w_got;
    logic              ar_got;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Every byte of the fill depends on the word index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~8'(i), 8'(i), 8'(i) ^ 8'hA5, 8'(i) + 8'h11};
        end
    end

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_axi   <= '0;
            rng     <= 32'd30;         // Fixed seed
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            ar_got  <= 1'b0;
            aw_dly  <= 2'd0;
            w_dly   <= 2'd1;
            ar_dly  <= 2'd2;
            rsp_dly <= 2'd0;
        end else begin
            rng <= xorshift32(rng);

            // AW channel
            if (i_axi.awvalid && o_axi.awready) begin
                o_axi.awready <= 1'b0;
                aw_got        <= 1'b1;
                wr_addr       <= i_axi.awaddr;
                aw_dly        <= rng[1:0];
            end else if (i_axi.awvalid && !aw_got) begin
                if (aw_dly == 2'd0) o_axi.awready <= 1'b1;
                else aw_dly <= aw_dly - 2'd1;
            end

            // W channel, may land before AW
            if (i_axi.wvalid && o_axi.wready) begin
                o_axi.wready <= 1'b0;
                w_got        <= 1'b1;
                wr_data      <= i_axi.wdata;
                wr_strb      <= i_axi.wstrb;
                w_dly        <= rng[3:2];
            end else if (i_axi.wvalid && !w_got) begin
                if (w_dly == 2'd0) o_axi.wready <= 1'b1;
                else w_dly <= w_dly - 2'd1;
            end

            // AR channel
            if (i_axi.arvalid && o_axi.arready) begin
                o_axi.arready <= 1'b0;
                ar_got        <= 1'b1;
                rd_addr       <= i_axi.araddr;
                ar_dly        <= rng[5:4];
            end else if (i_axi.arvalid && !ar_got) begin
                if (ar_dly == 2'd0) o_axi.arready <= 1'b1;
                else ar_dly <= ar_dly - 2'd1;
            end

            // B after both AW and W, store happens here
            if (o_axi.bvalid) begin
                if (i_axi.bready) o_axi.bvalid <= 1'b0;
            end else if (aw_got && w_got) begin
                if (rsp_dly == 2'd0) begin
                    if (wr_addr < ERR_BASE) begin
                        for (int b = 0; b < STRB_W; b++) begin
                            if (wr_strb[b]) mem[wr_addr[9:2]][8*b +: 8] <= wr_data[8*b +: 8];
                        end
                        o_axi.bresp <= RESP_OKAY;
                    end else begin
                        o_axi.bresp <= RESP_SLVERR;   // Nothing stored
                    end
                    o_axi.bvalid <= 1'b1;
                    aw_got       <= 1'b0;
                    w_got        <= 1'b0;
                    rsp_dly      <= rng[7:6];
                end else begin
                    rsp_dly <= rsp_dly - 2'd1;
                end
            end

            // R after AR
            if (o_axi.rvalid) begin
                if (i_axi.rready) o_axi.rvalid <= 1'b0;
            end else if (ar_got) begin
                if (rsp_dly == 2'd0) begin
                    o_axi.rvalid <= 1'b1;
                    ar_got       <= 1'b0;
                    rsp_dly      <= rng[9:8];
                    if (rd_addr < ERR_BASE) begin
                        o_axi.rdata <= mem[rd_addr[9:2]];
                        o_axi.rresp <= RESP_OKAY;
                    end else begin
                        o_axi.rdata <= '0;
                        o_axi.rresp <= RESP_SLVERR;
                    end
                end else begin
                    rsp_dly <= rsp_dly - 2'd1;
                end
            end
        end
    end

endmodule : axi_mem_model

`default_nettype wire

// File: sim/tb_core_bus_bridge.sv
// Testbench for the core memory bus bridge
// Three requesters share an AXI4-Lite memory model while a scoreboard
// memory and concurrent assertions check the results and the AXI rules
`timescale 1ns/1ps
`default_nettype none

module tb_core_bus_bridge import core_bus_pkg::*; ();

    localparam int                TMO      = 200;          // Cycles per wait
    localparam logic [ADDR_W-1:0] ERR_BASE = 32'h0000_0800;

    logic                           clk;
    logic                           rst_n;
    logic [NUM_REQ-1:0]             valid;
    bus_req_t [NUM_REQ-1:0]         req;
    logic [NUM_REQ-1:0]             ready;
    logic [NUM_REQ-1:0][DATA_W-1:0] rdata;
    logic [NUM_REQ-1:0]             err;
    axi_m2s_t                       m2s;
    axi_s2m_t                       s2m;

    logic [DATA_W-1:0] sb [256];   // Expected memory contents
    int                chk_cnt     = 0;
    int                err_cnt     = 0;
    int                pulse_cnt   = 0;
    int                last_served = NUM_REQ - 1;
    int                order [$];  // Requesters in order of completion
    logic [31:0]       rng;
    logic [STRB_W-1:0] seen_wstrb;  // Last W transfer at the port
    logic [DATA_W-1:0] seen_wdata;

    core_bus_bridge dut (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_valid (valid),
        .i_req   (req),
        .o_ready (ready),
        .o_rdata (rdata),
        .o_err   (err),
        .o_axi   (m2s),
        .i_axi   (s2m)
    );

    axi_mem_model u_mem (.i_clk(clk), .i_rst_n(rst_n), .i_axi(m2s), .o_axi(s2m));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) pulse_cnt <= pulse_cnt + $countones(ready);
        if (m2s.wvalid && s2m.wready) begin
            seen_wstrb <= m2s.wstrb;
            seen_wdata <= m2s.wdata;
        end
    end

    task automatic report_violation(input string what);
        err_cnt++;
        $display("Protocol check failed: %s", what);
    endtask

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ready))
        else report_violation("o_ready high for more than one requester");
    assert property (@(posedge clk) disable iff (!rst_n)
        m2s.awvalid && !s2m.awready |=> m2s.awvalid && $stable(m2s.awaddr))
        else report_violation("awvalid or awaddr changed before awready");
    assert property (@(posedge clk) disable iff (!rst_n) m2s.wvalid && !s2m.wready
        |=> m2s.wvalid && $stable(m2s.wdata) && $stable(m2s.wstrb))
        else report_violation("wvalid, wdata or wstrb changed before wready");
    assert property (@(posedge clk) disable iff (!rst_n)
        m2s.arvalid && !s2m.arready |=> m2s.arvalid && $stable(m2s.araddr))
        else report_violation("arvalid or araddr changed before arready");
    assert property (@(posedge clk) disable iff (!rst_n)
        (m2s.awaddr[1:0] == 2'b00) && (m2s.araddr[1:0] == 2'b00))
        else report_violation("AXI address not word aligned");
    assert property (@(posedge clk) disable iff (!rst_n) m2s.bready)
        else report_violation("bready low out of reset");

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Zero-extended lane picked by size and byte offset
    function automatic logic [31:0] lane_read(input logic [31:0] word, input size_e sz,
                                              input logic [1:0] off);
        case (sz)
            SIZE_BYTE: return {24'h0, word[8*off +: 8]};
            SIZE_HALF: return {16'h0, word[16*off[1] +: 16]};
            default:   return word;
        endcase
    endfunction

    task automatic sb_write(input logic [31:0] addr, input size_e sz, input logic [31:0] wd);
        case (sz)
            SIZE_BYTE: sb[addr[9:2]][8*addr[1:0] +: 8]  = wd[7:0];
            SIZE_HALF: sb[addr[9:2]][16*addr[1] +: 16]  = wd[15:0];
            default:   sb[addr[9:2]]                    = wd;
        endcase
    endtask

    task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("** Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic abort_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TMO, what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // One access by requester k started on a falling edge
    task automatic run_access(input int k, input logic wen, input size_e sz,
                              input logic [31:0] addr, input logic [31:0] wd);
        logic [31:0] got_data;
        logic        got_err;
        logic        exp_err;
        int          n;
        exp_err  = (addr >= ERR_BASE);
        req[k]   = '{wen: wen, size: sz, addr: addr, wdata: wd};
        valid[k] = 1'b1;
        for (n = 0; n < TMO; n++) begin
            @(negedge clk);
            if (ready[k]) break;
        end
        if (!ready[k]) begin
            abort_timeout($sformatf("o_ready[%0d]", k));
        end else begin
            got_data    = rdata[k];
            got_err     = err[k];
            valid[k]    = 1'b0;              // Re-raised at once by a following call
            last_served = k;
            order.push_back(k);
            check_hex($sformatf("o_err[%0d]", k), {31'h0, exp_err}, {31'h0, got_err});
            if (wen && !exp_err) sb_write(addr, sz, wd);
            if (!wen && !exp_err) begin
                check_hex($sformatf("o_rdata[%0d]", k),
                          lane_read(sb[addr[9:2]], sz, addr[1:0]), got_data);
            end
        end
    endtask

    task automatic check_idle_outputs();
        check_hex("o_ready", 32'h0, 32'(ready));
        check_hex("awvalid,wvalid,arvalid,rready", 32'h0,
                  {28'h0, m2s.awvalid, m2s.wvalid, m2s.arvalid, m2s.rready});
        check_hex("bready", 32'h1, {31'h0, m2s.bready});
    endtask

    task automatic test_done(input string name, input int errs_before);
        $display("Test %-12s done, %0d errors", name, err_cnt - errs_before);
    endtask

    initial begin
        int          e0;
        int          first;
        int          p0;
        int          rk;
        size_e       sz;
        logic [31:0] a;
        logic [7:0]  bval;
        logic [15:0] hval;
        logic        wr;
        valid = '0;
        req   = '0;
        rst_n = 1'b0;
        rng   = 32'd30;
        for (int i = 0; i < 256; i++) begin
            sb[i] = {~8'(i), 8'(i), 8'(i) ^ 8'hA5, 8'(i) + 8'h11};
        end

        // Reset values during reset and one cycle after
        e0 = err_cnt;
        repeat (5) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        test_done("reset", e0);

        // Word write and read back per requester
        e0 = err_cnt;
        for (int k = 0; k < NUM_REQ; k++) begin
            run_access(k, 1'b1, SIZE_WORD, 32'h40 + 32'(16*k),
                       32'h1234_5600 + 32'(k) * 32'h1111_0011);
        end
        for (int k = 0; k < NUM_REQ; k++) begin
            run_access(k, 1'b0, SIZE_WORD, 32'h40 + 32'(16*k), 32'h0);
        end
        test_done("word", e0);

        // Sub-word lanes with junk in the unused upper write bits
        e0 = err_cnt;
        for (int off = 0; off < 4; off++) begin
            bval = 8'hC0 + 8'(off);
            run_access(2, 1'b1, SIZE_BYTE, 32'h80 + 32'(off), {24'hDEADBE, bval});
            check_hex("wstrb", {28'h0, 4'b0001 << off}, {28'h0, seen_wstrb});
            check_hex("wdata", {4{bval}}, seen_wdata);
        end
        for (int h = 0; h < 2; h++) begin
            hval = 16'hBEE0 + 16'(h);
            run_access(2, 1'b1, SIZE_HALF, 32'h84 + 32'(2*h), {16'hF00D, hval});
            check_hex("wstrb", {28'h0, (h == 1) ? 4'b1100 : 4'b0011}, {28'h0, seen_wstrb});
            check_hex("wdata", {2{hval}}, seen_wdata);
        end
        for (int off = 0; off < 4; off++) run_access(1, 1'b0, SIZE_BYTE, 32'h80 + 32'(off), 32'h0);
        run_access(1, 1'b0, SIZE_HALF, 32'h84, 32'h0);
        run_access(1, 1'b0, SIZE_HALF, 32'h86, 32'h0);
        run_access(0, 1'b0, SIZE_WORD, 32'h80, 32'h0);
        run_access(0, 1'b0, SIZE_WORD, 32'h84, 32'h0);
        test_done("subword", e0);

        // All three keep requesting and grants rotate from the last served
        e0 = err_cnt;
        order.delete();
        first = (last_served + 1) % NUM_REQ;
        @(negedge clk);                      // Previous pulse already counted
        p0 = pulse_cnt;
        fork
            for (int i = 0; i < 3; i++) run_access(0, 1'b0, SIZE_WORD, 32'h100 + 32'(4*i), 32'h0);
            for (int i = 0; i < 3; i++) run_access(1, 1'b0, SIZE_WORD, 32'h140 + 32'(4*i), 32'h0);
            for (int i = 0; i < 3; i++) run_access(2, 1'b0, SIZE_WORD, 32'h180 + 32'(4*i), 32'h0);
        join
        @(negedge clk);
        check_hex("o_ready pulse count", 32'd9, 32'(pulse_cnt - p0));
        for (int i = 0; i < order.size(); i++) begin
            check_hex("served requester", 32'((first + i) % NUM_REQ), 32'(order[i]));
        end
        test_done("fairness", e0);

        // Random accesses under random channel delays
        e0 = err_cnt;
        @(negedge clk);
        p0 = pulse_cnt;
        for (int i = 0; i < 40; i++) begin
            rng = xorshift32(rng);
            rk  = int'(rng % 32'd3);
            sz  = size_e'((rng[3:2] == 2'd3) ? 2'd2 : rng[3:2]);
            a   = {22'h0, rng[13:4]};
            wr  = rng[14];
            if (sz == SIZE_HALF) a[0] = 1'b0;
            if (sz == SIZE_WORD) a[1:0] = 2'b00;
            rng = xorshift32(rng);
            run_access(rk, wr, sz, a, rng);
        end
        @(negedge clk);                      // Last pulse counted on this cycle's rising edge
        check_hex("o_ready pulse count", 32'd40, 32'(pulse_cnt - p0));
        test_done("random", e0);

        // Error region followed by a normal access
        e0 = err_cnt;
        run_access(0, 1'b0, SIZE_WORD, 32'h900, 32'h0);
        run_access(1, 1'b1, SIZE_WORD, 32'h804, 32'hBAD0_BAD0);
        run_access(1, 1'b0, SIZE_WORD, 32'h004, 32'h0);   // Same model word as 0x804
        run_access(2, 1'b0, SIZE_WORD, 32'h040, 32'h0);
        test_done("error", e0);

        @(negedge clk);
        $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_core_bus_bridge

`default_nettype wire
